// ==== rtl/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define XLEN 32

// architectural register count, x0 included
`define REG_COUNT 32

`define PC_RESET 32'h0000_0000

`endif

// ==== rtl/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmt_s;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmt_s;

    // branch offset is split around the register fields
    typedef struct packed {
        logic        imm12;
        logic [5:0]  imm10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm4_1;
        logic        imm11;
        logic [6:0]  opcode;
    } bFmt_s;

    typedef struct packed {
        logic        imm20;
        logic [9:0]  imm10_1;
        logic        imm11;
        logic [7:0]  imm19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } jFmt_s;

    // same word, seen through each format
    typedef union packed {
        rFmt_s r;
        iFmt_s i;
        bFmt_s b;
        jFmt_s j;
    } instrWord_u;

endpackage

`default_nettype wire

// ==== rtl/rvCtrlPkg.sv ====
`default_nettype none

package rvCtrlPkg;

    // ALU operation codes
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLL = 3'b101
    } aluOp_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'b00, // R-type has no immediate
        IMM_I    = 2'b01,
        IMM_B    = 2'b10,
        IMM_J    = 2'b11
    } immSrc_e;

    typedef enum logic {
        RES_ALU      = 1'b0,
        RES_PC_PLUS4 = 1'b1  // link value for jal/jalr
    } resultSrc_e;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_BRANCH = 2'b01,   // pc + imm for branches and jal
        PC_JALR   = 2'b10
    } pcSrc_e;

    typedef enum logic [1:0] {
        FETCH = 2'b00,
        EXEC  = 2'b01,
        WB    = 2'b10
    } cpuState_e;

endpackage

`default_nettype wire

// ==== rtl/ctrlIf.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

interface ctrlIf import rvCtrlPkg::*;;

    logic              regWrite;
    logic              aluSrc;   // 1 selects imm as operand b
    aluOp_e            aluCtrl;
    immSrc_e           immSrc;
    resultSrc_e        resultSrc;
    pcSrc_e            pcSrc;
    logic [`XLEN-1:0]  imm;

    modport decoder (output regWrite, aluSrc, aluCtrl, immSrc, resultSrc, pcSrc, imm);

    modport exec (input aluSrc, aluCtrl, imm);

    modport pc (input pcSrc, imm);

endinterface

`default_nettype wire

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module instrDecoder import rvIsaPkg::*, rvCtrlPkg::*; (
    input  instrWord_u    instr,
    input  logic          zero,
    ctrlIf.decoder        ctrl
);

    // controls from opcode/funct3/funct7
    always_comb begin
        // safe defaults, anything unknown retires as a no-op
        ctrl.regWrite  = 1'b0;
        ctrl.aluSrc    = 1'b0;
        ctrl.aluCtrl   = ALU_ADD;
        ctrl.immSrc    = IMM_NONE;
        ctrl.resultSrc = RES_ALU;
        ctrl.pcSrc     = PC_PLUS4;

        case (instr.r.opcode)
            OP_IMM: begin
                ctrl.aluSrc = 1'b1;
                ctrl.immSrc = IMM_I;
                if (instr.i.funct3 == 3'b000) begin // addi
                    ctrl.regWrite = 1'b1;
                end else if (instr.i.funct3 == 3'b001 && instr.r.funct7 == 7'b0) begin
                    ctrl.regWrite = 1'b1; // slli
                    ctrl.aluCtrl  = ALU_SLL;
                end
            end
            OP_REG: begin
                ctrl.regWrite = 1'b1;
                case ({instr.r.funct7, instr.r.funct3})
                    {7'b0000000, 3'b000}: ctrl.aluCtrl = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.aluCtrl = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl.aluCtrl = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl.aluCtrl = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl.aluCtrl = ALU_XOR;
                    default:              ctrl.regWrite = 1'b0;
                endcase
            end
            OP_BRANCH: begin
                ctrl.immSrc = IMM_B;
                // taken branch picks the pc + imm target
                if (instr.b.funct3 == 3'b000 && zero) begin
                    ctrl.pcSrc = PC_BRANCH; // beq
                end else if (instr.b.funct3 == 3'b001 && !zero) begin
                    ctrl.pcSrc = PC_BRANCH; // bne
                end
            end
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_J;
                ctrl.resultSrc = RES_PC_PLUS4;
                ctrl.pcSrc     = PC_BRANCH; // always taken
            end
            OP_JALR: begin
                if (instr.i.funct3 == 3'b000) begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrc    = 1'b1; // rs1 + imm in the ALU
                    ctrl.immSrc    = IMM_I;
                    ctrl.resultSrc = RES_PC_PLUS4;
                    ctrl.pcSrc     = PC_JALR;
                end
            end
            default: ;
        endcase
    end

    // sign-extended immediate, assembled from the matching view
    always_comb begin
        case (ctrl.immSrc)
            IMM_I:   ctrl.imm = {{(`XLEN-12){instr.i.imm11_0[11]}}, instr.i.imm11_0};
            IMM_B:   ctrl.imm = {{(`XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                                 instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            IMM_J:   ctrl.imm = {{(`XLEN-21){instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                                 instr.j.imm11, instr.j.imm10_1, 1'b0};
            default: ctrl.imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/cycleSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module cycleSequencer import rvCtrlPkg::*; (
    input  logic       clk,
    input  logic       rst,
    output cpuState_e  state,
    output logic       fetchEn,
    output logic       execEn,
    output logic       wbPhase
);

    cpuState_e nextState;

    // fixed ring, one instruction every three cycles
    always_comb begin
        case (state)
            FETCH:   nextState = EXEC;
            EXEC:    nextState = WB;
            WB:      nextState = FETCH;
            default: nextState = FETCH; // unused encoding recovers
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    assign fetchEn = (state == FETCH); // instruction register load
    assign execEn  = (state == EXEC);  // result latch
    assign wbPhase = (state == WB);

endmodule

`default_nettype wire

// ==== rtl/pcCounter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module pcCounter import rvCtrlPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              wbPhase,
    ctrlIf.pc                 ctrl,
    input  logic [`XLEN-1:0]  aluResult,
    output logic [`XLEN-1:0]  pc,
    output logic [`XLEN-1:0]  pcPlus4
);

    logic [`XLEN-1:0] pcNext;

    assign pcPlus4 = pc + `XLEN'd4;

    always_comb begin
        case (ctrl.pcSrc)
            PC_BRANCH: pcNext = pc + ctrl.imm;
            PC_JALR:   pcNext = {aluResult[`XLEN-1:1], 1'b0}; // target bit 0 cleared
            default:   pcNext = pcPlus4;
        endcase
    end

    // pc moves only at the end of writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `PC_RESET;
        end else if (wbPhase) begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module regFile #(
    parameter int addrWidth = $clog2(`REG_COUNT)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [addrWidth-1:0]  rs1Addr,
    input  logic [addrWidth-1:0]  rs2Addr,
    output logic [`XLEN-1:0]      rs1Data,
    output logic [`XLEN-1:0]      rs2Data,
    input  logic                  we,
    input  logic [addrWidth-1:0]  wAddr,
    input  logic [`XLEN-1:0]      wData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 is never written, so ignore its slot here
    always_ff @(posedge clk) begin
        if (we && !rst && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // asynchronous reads, x0 hardwired to zero
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// ==== rtl/execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module execUnit import rvCtrlPkg::*; (
    input  logic              clk,
    input  logic              execEn,
    input  logic [`XLEN-1:0]  rs1Data,
    input  logic [`XLEN-1:0]  rs2Data,
    ctrlIf.exec               ctrl,
    output logic [`XLEN-1:0]  aluResult,
    output logic              zero
);

    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] diff;

    assign opB = ctrl.aluSrc ? ctrl.imm : rs2Data;

    always_comb begin
        case (ctrl.aluCtrl)
            ALU_ADD: aluOut = rs1Data + opB;
            ALU_SUB: aluOut = rs1Data - opB;
            ALU_AND: aluOut = rs1Data & opB;
            ALU_OR:  aluOut = rs1Data | opB;
            ALU_XOR: aluOut = rs1Data ^ opB;
            ALU_SLL: aluOut = rs1Data << opB[4:0]; // shamt from low 5 bits
            default: aluOut = '0;
        endcase
    end

    // result held through writeback
    always_ff @(posedge clk) begin
        if (execEn) begin
            aluResult <= aluOut;
        end
    end

    // branch compare always on the two registers, independent of aluSrc
    assign diff = rs1Data - rs2Data;
    assign zero = (diff == '0);

endmodule

`default_nettype wire

// ==== rtl/rvCore.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module rvCore import rvIsaPkg::*, rvCtrlPkg::*; (
    input  logic              clk,
    input  logic              rst,
    output logic [`XLEN-1:0]  pc,
    input  logic [31:0]       instr,   // combinational fetch data
    output logic              retire,
    output logic              wbEn,
    output logic [4:0]        wbAddr,
    output logic [`XLEN-1:0]  wbData
);

    cpuState_e         seqState;
    logic              fetchEn;
    logic              execEn;
    logic              wbPhase;
    instrWord_u        instrReg;
    logic [`XLEN-1:0]  rs1Data;
    logic [`XLEN-1:0]  rs2Data;
    logic [`XLEN-1:0]  aluResult;
    logic [`XLEN-1:0]  pcPlus4;
    logic              zero;

    ctrlIf ctrl ();

    cycleSequencer seq_i (
        .clk     (clk),
        .rst     (rst),
        .state   (seqState),
        .fetchEn (fetchEn),
        .execEn  (execEn),
        .wbPhase (wbPhase)
    );

    // instruction register, captured at the end of fetch
    always_ff @(posedge clk) begin
        if (fetchEn) begin
            instrReg <= instr;
        end
    end

    instrDecoder dec_i (.instr(instrReg), .zero(zero), .ctrl(ctrl.decoder));

    regFile rf_i (
        .clk     (clk),
        .rst     (rst),
        .rs1Addr (instrReg.r.rs1),
        .rs2Addr (instrReg.r.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .we      (wbEn),
        .wAddr   (wbAddr),
        .wData   (wbData)
    );

    execUnit exe_i (
        .clk       (clk),
        .execEn    (execEn),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .ctrl      (ctrl.exec),
        .aluResult (aluResult),
        .zero      (zero)
    );

    pcCounter pc_i (
        .clk       (clk),
        .rst       (rst),
        .wbPhase   (wbPhase),
        .ctrl      (ctrl.pc),
        .aluResult (aluResult),
        .pc        (pc),
        .pcPlus4   (pcPlus4)
    );

    assign retire = (seqState == WB);
    assign wbAddr = instrReg.r.rd;
    assign wbEn   = ctrl.regWrite && wbPhase && (instrReg.r.rd != 5'd0); // x0 never written
    assign wbData = (ctrl.resultSrc == RES_PC_PLUS4) ? pcPlus4 : aluResult;

endmodule

`default_nettype wire

// ==== tests/rvCore_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module rvCoreProperties (
    input logic              clk,
    input logic              rst,
    input logic              retire,
    input logic              wbEn,
    input logic [4:0]        wbAddr,
    input logic [`XLEN-1:0]  pc
);

    // retire every third cycle, never closer
    retireRecurs: assert property (@(posedge clk) disable iff (rst) $past(retire, 3) |-> retire)
        else $error("retire did not recur three cycles after the previous one");

    retireSpacing: assert property (@(posedge clk) disable iff (rst)
        retire |-> !$past(retire) && !$past(retire, 2))
        else $error("retire came less than three cycles after the previous one");

    wbEnQualified: assert property (@(posedge clk) disable iff (rst)
        wbEn |-> retire && wbAddr != 5'd0)
        else $error("wbEn high outside writeback or with rd of x0");

    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

endmodule

bind rvCore rvCoreProperties props_i (
    .clk    (clk),
    .rst    (rst),
    .retire (retire),
    .wbEn   (wbEn),
    .wbAddr (wbAddr),
    .pc     (pc)
);

`default_nettype wire

// ==== tests/rvCore_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module rvCore_tb;

    localparam int progLen      = 64;
    localparam int retireTarget = 400;
    localparam int cycleLimit   = 3 * retireTarget + 50;

    // instruction kinds held next to each program slot
    localparam int kAddi = 0;
    localparam int kSlli = 1;
    localparam int kAdd  = 2;
    localparam int kSub  = 3;
    localparam int kAnd  = 4;
    localparam int kOr   = 5;
    localparam int kXor  = 6;
    localparam int kBeq  = 7;
    localparam int kBne  = 8;
    localparam int kJal  = 9;
    localparam int kJalr = 10;
    localparam int kBad  = 11; // encodings the core must ignore

    logic              clk;
    logic              rst;
    logic [`XLEN-1:0]  pc;
    logic [31:0]       instr;
    logic              retire;
    logic              wbEn;
    logic [4:0]        wbAddr;
    logic [`XLEN-1:0]  wbData;

    logic [31:0]       prog  [progLen];
    int                kind  [progLen];
    logic [4:0]        rdOf  [progLen];
    logic [4:0]        rs1Of [progLen];
    logic [4:0]        rs2Of [progLen];
    logic [31:0]       immOf [progLen];

    logic [`XLEN-1:0]  modelRegs [`REG_COUNT];
    logic [`XLEN-1:0]  modelPc;

    int                seed;
    int                errorCount;
    int                checkCount;
    int                cycleCount;
    int                retireCount;
    logic              timedOut;
    logic [5:0]        idx;
    logic              expWe;
    logic [31:0]       expData;

    rvCore dut_i (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .instr  (instr),
        .retire (retire),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // RV32I encoders for the base formats
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic buildProgram();
        logic [31:0] rnd;
        int          target;
        for (int i = 0; i < progLen; i++) begin
            rnd       = $random(seed);
            rdOf[i]   = {2'b00, rnd[2:0]}; // x0..x7 only
            rs1Of[i]  = {2'b00, rnd[5:3]};
            rs2Of[i]  = {2'b00, rnd[8:6]};
            immOf[i]  = {{20{rnd[31]}}, rnd[31:20]};
            target    = randBelow(progLen);
            if (i < 7) begin // seed x1..x7 before anything reads them
                kind[i]  = kAddi;
                rdOf[i]  = 5'(i + 1);
                rs1Of[i] = 5'd0;
            end else if (i == progLen - 1) begin
                kind[i] = kJal;
                rdOf[i] = 5'd0;
                target  = 0;
            end else begin
                kind[i] = randBelow(kBad + 1);
            end
            case (kind[i])
                kSlli:             immOf[i] = {27'b0, rnd[24:20]};
                kBeq, kBne, kJal:  immOf[i] = (target - i) * 4; // word-aligned and in range
                kJalr: begin
                    rs1Of[i] = 5'd0;
                    immOf[i] = target * 4 + (rnd[9] ? 1 : 0); // odd target tests bit 0
                end
                default: ;
            endcase
            case (kind[i])
                kAddi: prog[i] = encI(immOf[i][11:0], rs1Of[i], 3'b000, rdOf[i], 7'b0010011);
                kSlli: prog[i] = encI(immOf[i][11:0], rs1Of[i], 3'b001, rdOf[i], 7'b0010011);
                kAdd:  prog[i] = encR(7'h00, rs2Of[i], rs1Of[i], 3'b000, rdOf[i]);
                kSub:  prog[i] = encR(7'h20, rs2Of[i], rs1Of[i], 3'b000, rdOf[i]);
                kAnd:  prog[i] = encR(7'h00, rs2Of[i], rs1Of[i], 3'b111, rdOf[i]);
                kOr:   prog[i] = encR(7'h00, rs2Of[i], rs1Of[i], 3'b110, rdOf[i]);
                kXor:  prog[i] = encR(7'h00, rs2Of[i], rs1Of[i], 3'b100, rdOf[i]);
                kBeq:  prog[i] = encB(immOf[i][12:0], rs2Of[i], rs1Of[i], 3'b000);
                kBne:  prog[i] = encB(immOf[i][12:0], rs2Of[i], rs1Of[i], 3'b001);
                kJal:  prog[i] = encJ(immOf[i][20:0], rdOf[i]);
                kJalr: prog[i] = encI(immOf[i][11:0], rs1Of[i], 3'b000, rdOf[i], 7'b1100111);
                default: begin
                    // lw, mul and slti are all outside the subset
                    case (randBelow(3))
                        0:       prog[i] = encI(rnd[31:20], rs1Of[i], 3'b010, rdOf[i],
                                                7'b0000011);
                        1:       prog[i] = encR(7'h01, rs2Of[i], rs1Of[i], 3'b000, rdOf[i]);
                        default: prog[i] = encI(rnd[31:20], rs1Of[i], 3'b010, rdOf[i],
                                                7'b0010011);
                    endcase
                end
            endcase
        end
    endtask

    // one architectural step of the instruction at slot n
    task automatic stepModel(input logic [5:0] n, output logic we, output logic [31:0] data);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] nextPc;
        logic        writes;
        a      = modelRegs[rs1Of[n]];
        b      = modelRegs[rs2Of[n]];
        writes = 1'b1;
        nextPc = modelPc + 32'd4;
        data   = '0;
        case (kind[n])
            kAddi: data = a + immOf[n];
            kSlli: data = a << immOf[n][4:0];
            kAdd:  data = a + b;
            kSub:  data = a - b;
            kAnd:  data = a & b;
            kOr:   data = a | b;
            kXor:  data = a ^ b;
            kBeq: begin
                writes = 1'b0;
                if (a == b) nextPc = modelPc + immOf[n];
            end
            kBne: begin
                writes = 1'b0;
                if (a != b) nextPc = modelPc + immOf[n];
            end
            kJal: begin
                data   = modelPc + 32'd4;
                nextPc = modelPc + immOf[n];
            end
            kJalr: begin
                data   = modelPc + 32'd4;
                nextPc = (a + immOf[n]) & ~32'h1;
            end
            default: writes = 1'b0;
        endcase
        we = writes && (rdOf[n] != 5'd0);
        if (we) modelRegs[rdOf[n]] = data;
        modelPc = nextPc;
    endtask

    initial begin
        seed        = 32'hb7c1e997;
        rst         = 1'b1;
        instr       = '0;
        errorCount  = 0;
        checkCount  = 0;
        cycleCount  = 0;
        retireCount = 0;
        timedOut    = 1'b0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            modelRegs[r] = '0;
        end
        modelPc = `PC_RESET;
        buildProgram();

        repeat (4) @(negedge clk);
        rst = 1'b0;

        // one pass per falling edge starting in the first fetch cycle
        while (retireCount < retireTarget) begin
            instr = prog[pc[7:2]];
            if (cycleCount == 0) checkValue("pc", pc, `PC_RESET);
            checkValue("retire", {31'b0, retire}, {31'b0, (cycleCount % 3 == 2)});
            if (retire) begin
                idx = modelPc[7:2];
                checkValue("pc", pc, modelPc);
                stepModel(idx, expWe, expData);
                checkValue("wbEn", {31'b0, wbEn}, {31'b0, expWe});
                if (expWe) begin
                    checkValue("wbAddr", {27'b0, wbAddr}, {27'b0, rdOf[idx]});
                    checkValue("wbData", wbData, expData);
                end
                retireCount++;
            end else begin
                checkValue("wbEn", {31'b0, wbEn}, 32'd0); // writes only in WB
            end
            cycleCount++;
            if (cycleCount >= cycleLimit) begin
                timedOut = 1'b1;
                $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                         retireCount, retireTarget, cycleCount);
                break;
            end
            @(negedge clk);
        end

        $display("retired %0d, checks %0d, errors %0d, timeouts %0d",
                 retireCount, checkCount, errorCount, timedOut ? 1 : 0);
        if (errorCount == 0 && !timedOut) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rvCore.f ====
+incdir+rtl
rtl/rvIsaPkg.sv
rtl/rvCtrlPkg.sv
rtl/ctrlIf.sv
rtl/instrDecoder.sv
rtl/cycleSequencer.sv
rtl/pcCounter.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/rvCore.sv
tests/rvCore_properties.sv
tests/rvCore_tb.sv

// ==== Makefile ====
# Verilator build and run of the rvCore testbench

all: run

compile:
	verilator --binary --timing --assert -f rvCore.f --top-module rvCore_tb -Mdir obj_dir -o rvCore_sim

run: compile
	./obj_dir/rvCore_sim | tee sim.log
	@if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
